// File: logic/tcp_tx_pkg.sv
package tcp_tx_pkg;

  typedef logic [31:0] seq_t;   // tcp sequence / ack number
  typedef logic [15:0] len_t;   // payload length in bytes
  typedef logic [31:0] cks_t;   // unfolded sum of 16-bit big-endian words
  typedef logic [7:0]  byte_t;  // stream byte
  typedef logic [7:0]  tries_t; // retransmission count
  typedef logic [31:0] tick_t;  // retransmit timer

  ////////////////////
  // packet record layout, lsb first
  ////////////////////
  localparam int PKT_PRESENT_W = 1;
  localparam int PKT_START_W   = $bits(seq_t);
  localparam int PKT_STOP_W    = $bits(seq_t);
  localparam int PKT_LEN_W     = $bits(len_t);
  localparam int PKT_CKS_W     = $bits(cks_t);
  localparam int PKT_TRIES_W   = $bits(tries_t);
  localparam int PKT_TIMER_W   = $bits(tick_t);

  localparam int PKT_PRESENT_LSB = 0;                              // record holds a live segment
  localparam int PKT_START_LSB   = PKT_PRESENT_LSB + PKT_PRESENT_W; // first seq of segment
  localparam int PKT_STOP_LSB    = PKT_START_LSB + PKT_START_W;     // expected ack
  localparam int PKT_LEN_LSB     = PKT_STOP_LSB + PKT_STOP_W;
  localparam int PKT_CKS_LSB     = PKT_LEN_LSB + PKT_LEN_W;
  localparam int PKT_TRIES_LSB   = PKT_CKS_LSB + PKT_CKS_W;
  localparam int PKT_TIMER_LSB   = PKT_TRIES_LSB + PKT_TRIES_W;

  localparam int PKT_INFO_W = PKT_TIMER_LSB + PKT_TIMER_W; // 153 bits total

  typedef logic [PKT_INFO_W-1:0] pkt_info_t;

endpackage

// File: logic/tcp_tx_data_buf.sv
`timescale 1ns/1ps

module tcp_tx_data_buf #(
  parameter int BUF_AW = 10
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              init,
  input  tcp_tx_pkg::seq_t  ack_seq, // bytes below this are free
  input  tcp_tx_pkg::seq_t  wr_seq,  // seq of the byte being written
  input  logic              write,
  input  tcp_tx_pkg::byte_t wr_dat,
  input  logic [BUF_AW-1:0] rd_addr,
  output tcp_tx_pkg::byte_t rd_dat,
  output logic              full
);
  import tcp_tx_pkg::*;

  localparam int DEPTH = 2**BUF_AW;

  byte_t mem [DEPTH]; // circular store, indexed by low seq bits
  seq_t  wr_next;     // write pointer after this cycle
  seq_t  used_next;   // bytes held after this cycle

  ////////////////////
  // occupancy
  ////////////////////
  assign wr_next   = write ? wr_seq + 1'b1 : wr_seq;
  assign used_next = wr_next - ack_seq; // wraps huge if ack runs ahead, reads as full

  // registered flag, an ack shows up one cycle late which only delays reopening
  always_ff @(posedge clk) begin
    if (reset || init) begin
      full <= 1'b0; // empty after init
    end else begin
      full <= (used_next >= seq_t'(DEPTH));
    end
  end

  ////////////////////
  // byte ram
  ////////////////////
  always_ff @(posedge clk) begin
    if (write) begin
      mem[wr_seq[BUF_AW-1:0]] <= wr_dat;
    end
    rd_dat <= mem[rd_addr]; // one cycle read
  end

endmodule

// File: logic/tcp_tx_pkt_ram.sv
`timescale 1ns/1ps

module tcp_tx_pkt_ram #(
  parameter int PKT_AW = 3
) (
  input  logic                  clk,
  input  logic [PKT_AW-1:0]     a_addr, // packetizer side
  input  logic                  a_wr,
  input  tcp_tx_pkg::pkt_info_t a_dat,
  output tcp_tx_pkg::pkt_info_t a_q,
  input  logic [PKT_AW-1:0]     b_addr, // scanner side
  input  logic                  b_wr,
  input  tcp_tx_pkg::pkt_info_t b_dat,
  output tcp_tx_pkg::pkt_info_t b_q
);
  import tcp_tx_pkg::*;

  pkt_info_t mem [2**PKT_AW];

  // port a, read returns old contents on a same-address write
  always @(posedge clk) begin
    if (a_wr) mem[a_addr] <= a_dat;
    a_q <= mem[a_addr];
  end

  // port b
  always @(posedge clk) begin
    if (b_wr) mem[b_addr] <= b_dat;
    b_q <= mem[b_addr];
  end

endmodule

// File: logic/tcp_tx_packetizer.sv
`timescale 1ns/1ps

module tcp_tx_packetizer #(
  parameter int MTU_PLD    = 1460,
  parameter int WAIT_TICKS = 20,
  parameter int RETX_TICKS = 1000,
  parameter int PKT_AW     = 3
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  init,
  input  tcp_tx_pkg::seq_t      init_seq,
  input  logic                  connected,
  input  logic                  flush,
  input  tcp_tx_pkg::byte_t     in_dat,
  input  logic                  in_val,
  input  logic                  in_snd,
  output logic                  in_cts,
  input  logic                  buf_full,
  input  logic [PKT_AW:0]       pop_cnt,
  output tcp_tx_pkg::seq_t      loc_seq,
  output logic                  rec_wr,
  output logic [PKT_AW-1:0]     rec_addr,
  output tcp_tx_pkg::pkt_info_t rec_dat,
  output logic                  busy
);
  import tcp_tx_pkg::*;

  typedef enum logic {idle_s, pend_s} state_t;

  state_t                          state;
  logic [PKT_AW:0]                 push_ptr;
  logic [PKT_AW:0]                 rec_used; // stored records plus the one forming
  logic                            accept, load_pend;
  len_t                            ctr;      // bytes in current segment
  logic [$clog2(WAIT_TICKS+1)-1:0] idle_cnt;
  cks_t                            cks;
  byte_t                           hold;     // high byte of an unfinished word
  seq_t                            start_seq;

  assign rec_used  = push_ptr - pop_cnt + 1'b1;
  assign accept    = in_val && in_cts;
  assign load_pend = (state == pend_s) &&
                     (idle_cnt == WAIT_TICKS || ctr == MTU_PLD || buf_full || in_snd);
  // hold the user off while a segment closes so the record sees a stable loc_seq
  assign in_cts    = connected && !rec_used[PKT_AW] && !buf_full && !load_pend;
  assign busy      = load_pend || rec_wr; // scanner keeps off port b meanwhile
  assign rec_addr  = push_ptr[PKT_AW-1:0];

  always_ff @(posedge clk) begin
    if (reset) loc_seq <= '0;
    else if (init) loc_seq <= init_seq; // start of connection
    else if (accept) loc_seq <= loc_seq + 1'b1;
  end

  ////////////////////
  // segment fsm
  ////////////////////
  always_ff @(posedge clk) begin
    if (reset || init) begin
      state    <= idle_s;
      push_ptr <= '0;
      rec_wr   <= 1'b0;
      ctr      <= '0;
      idle_cnt <= '0;
    end else begin
      rec_wr <= load_pend && !flush; // record lands 1 cycle after the load condition
      if (rec_wr) push_ptr <= push_ptr + 1'b1;
      case (state)
        idle_s: begin
          if (accept) begin
            ctr      <= len_t'(1);
            idle_cnt <= '0;
            state    <= pend_s;
          end
        end
        pend_s: begin
          if (accept) ctr <= ctr + 1'b1;
          idle_cnt <= accept ? '0 : idle_cnt + 1'b1; // restart timeout on every byte
          if (load_pend) state <= idle_s;
        end
        default: state <= idle_s;
      endcase
    end
  end

  // checksum and record payload
  always_ff @(posedge clk) begin
    if (accept) begin
      hold <= in_dat;
      if (state == idle_s) begin
        start_seq <= loc_seq; // first byte of a new segment
        cks       <= '0;
      end else if (ctr[0]) begin
        cks <= cks + cks_t'({hold, in_dat}); // word complete
      end
    end
    if (load_pend) begin
      rec_dat[PKT_PRESENT_LSB]              <= 1'b1;
      rec_dat[PKT_START_LSB +: PKT_START_W] <= start_seq;
      rec_dat[PKT_STOP_LSB +: PKT_STOP_W]   <= loc_seq; // expected ack
      rec_dat[PKT_LEN_LSB +: PKT_LEN_W]     <= ctr;
      rec_dat[PKT_CKS_LSB +: PKT_CKS_W]     <= ctr[0] ? cks + cks_t'({hold, 8'h00}) : cks;
      rec_dat[PKT_TRIES_LSB +: PKT_TRIES_W] <= '0;
      rec_dat[PKT_TIMER_LSB +: PKT_TIMER_W] <= tick_t'(RETX_TICKS); // first visit sends it
    end
  end

endmodule

// File: logic/tcp_tx_retrans_ctl.sv
`timescale 1ns/1ps

module tcp_tx_retrans_ctl #(
  parameter int RETX_TICKS = 1000,
  parameter int RETX_TRIES = 5,
  parameter int BUF_AW     = 10,
  parameter int PKT_AW     = 3
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  init,
  input  tcp_tx_pkg::seq_t      rem_ack,
  input  logic                  flush,
  input  logic                  busy,
  output logic [PKT_AW-1:0]     rec_addr,
  output logic                  rec_wr,
  output tcp_tx_pkg::pkt_info_t rec_dat,
  input  tcp_tx_pkg::pkt_info_t rec_q,
  output logic [PKT_AW:0]       pop_cnt,
  output tcp_tx_pkg::seq_t      ack_seq,
  output logic [BUF_AW-1:0]     buf_addr,
  output tcp_tx_pkg::seq_t      pld_seq,
  output tcp_tx_pkg::len_t      pld_len,
  output tcp_tx_pkg::cks_t      pld_cks,
  output logic                  send,
  input  logic                  req,
  input  logic                  sent,
  output logic                  strm_val,
  output logic                  strm_sof,
  output logic                  strm_eof,
  output logic                  force_dcn,
  output logic                  flushed
);
  import tcp_tx_pkg::*;

  typedef enum logic [2:0] {
    idle_s, scan_s, choice_s, check_s, next_s, wait_s, retx_s, flush_s
  } state_t;

  state_t    state;
  pkt_info_t cur;                // record under inspection
  seq_t      ack_diff;           // stop - rem_ack, sign bit set means acked past it
  seq_t      adv;                // how far stop is ahead of ack_seq
  seq_t      cur_start, cur_stop;
  tick_t     cur_timer;
  tries_t    cur_tries;
  logic      free, retx, done, last;
  logic      init_clr;           // sweep started by init, no flushed pulse
  len_t      byte_cnt;

  assign cur_start = cur[PKT_START_LSB +: PKT_START_W];
  assign cur_stop  = cur[PKT_STOP_LSB +: PKT_STOP_W];
  assign cur_timer = cur[PKT_TIMER_LSB +: PKT_TIMER_W];
  assign cur_tries = cur[PKT_TRIES_LSB +: PKT_TRIES_W];
  assign adv       = cur_stop - ack_seq;
  assign last      = (byte_cnt == pld_len - 1'b1);

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= idle_s;
      rec_addr  <= '0;
      rec_wr    <= 1'b0;
      pop_cnt   <= '0;
      ack_seq   <= '0;
      send      <= 1'b0;
      strm_val  <= 1'b0;
      strm_sof  <= 1'b0;
      strm_eof  <= 1'b0;
      force_dcn <= 1'b0;
      flushed   <= 1'b0;
      init_clr  <= 1'b0;
      done      <= 1'b0;
    end else begin
      send     <= 1'b0; // pulses
      flushed  <= 1'b0;
      strm_val <= 1'b0;
      strm_sof <= 1'b0;
      strm_eof <= 1'b0;
      case (state)
        idle_s: if (init) begin
          ack_seq   <= rem_ack; // buffer free pointer starts at the remote ack
          pop_cnt   <= '0;
          force_dcn <= 1'b0;
          init_clr  <= 1'b1;    // wipe stale records first
          rec_addr  <= '0;
          rec_wr    <= 1'b1;
          rec_dat   <= '0;
          state     <= flush_s;
        end
        scan_s: begin
          if (flush) begin
            init_clr <= 1'b0;
            rec_addr <= '0;
            rec_wr   <= 1'b1;
            rec_dat  <= '0;
            state    <= flush_s;
          end else if (rec_q[PKT_PRESENT_LSB]) begin
            cur      <= rec_q;
            ack_diff <= rec_q[PKT_STOP_LSB +: PKT_STOP_W] - rem_ack;
            state    <= choice_s;
          end else begin
            rec_addr <= rec_addr + 1'b1; // empty slot
            state    <= wait_s;
          end
        end
        choice_s: begin
          free  <= ack_diff[31] || ack_diff == '0;
          retx  <= !ack_diff[31] && ack_diff != '0 && cur_timer == tick_t'(RETX_TICKS);
          state <= check_s;
        end
        check_s: if (!busy) begin // wait out a pending record load
          rec_wr  <= 1'b1;
          rec_dat <= cur;
          if (free) begin
            rec_dat[PKT_PRESENT_LSB]              <= 1'b0;
            rec_dat[PKT_TIMER_LSB +: PKT_TIMER_W] <= '0;
            rec_dat[PKT_TRIES_LSB +: PKT_TRIES_W] <= '0;
            state <= next_s;
          end else if (retx) begin
            rec_dat[PKT_TIMER_LSB +: PKT_TIMER_W] <= '0;
            rec_dat[PKT_TRIES_LSB +: PKT_TRIES_W] <= cur_tries + 1'b1;
            if (cur_tries == tries_t'(RETX_TRIES)) force_dcn <= 1'b1; // give up
            send     <= 1'b1;
            pld_seq  <= cur_start;
            pld_len  <= cur[PKT_LEN_LSB +: PKT_LEN_W];
            pld_cks  <= cur[PKT_CKS_LSB +: PKT_CKS_W];
            buf_addr <= cur_start[BUF_AW-1:0];
            byte_cnt <= '0;
            done     <= 1'b0;
            state    <= retx_s;
          end else begin
            rec_dat[PKT_TIMER_LSB +: PKT_TIMER_W] <= cur_timer + 1'b1; // keep, age it
            state <= next_s;
          end
        end
        next_s: begin
          rec_wr <= 1'b0;
          if (free) begin
            pop_cnt <= pop_cnt + 1'b1;
            if (!adv[31]) ack_seq <= cur_stop; // never move the free pointer back
          end
          rec_addr <= rec_addr + 1'b1;
          state    <= wait_s;
        end
        wait_s: state <= scan_s; // record ram read latency
        retx_s: begin
          rec_wr <= 1'b0;
          if (flush) begin
            init_clr <= 1'b0; // abort the readout
            rec_addr <= '0;
            rec_wr   <= 1'b1;
            rec_dat  <= '0;
            state    <= flush_s;
          end else begin
            if (req && !done) begin // one byte per req cycle, shows up next cycle
              strm_val <= 1'b1;
              strm_sof <= (byte_cnt == '0);
              strm_eof <= last;
              done     <= last;
              byte_cnt <= byte_cnt + 1'b1;
              buf_addr <= buf_addr + 1'b1;
            end
            if (sent) begin
              rec_addr <= rec_addr + 1'b1;
              state    <= wait_s;
            end
          end
        end
        flush_s: begin // one cleared record per cycle
          if (rec_addr == '1) begin
            rec_wr  <= 1'b0;
            flushed <= !init_clr;
            state   <= init_clr ? wait_s : idle_s;
          end else begin
            rec_addr <= rec_addr + 1'b1;
          end
        end
        default: state <= idle_s;
      endcase
    end
  end

endmodule

// File: logic/tcp_tx_ctl.sv
`timescale 1ns/1ps

module tcp_tx_ctl #(
  parameter int MTU_PLD    = 1460,
  parameter int WAIT_TICKS = 20,
  parameter int RETX_TICKS = 1000,
  parameter int RETX_TRIES = 5,
  parameter int BUF_AW     = 10,
  parameter int PKT_AW     = 3
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              init,      // one-cycle connection start
  input  tcp_tx_pkg::seq_t  init_seq,
  input  logic              connected,
  input  tcp_tx_pkg::seq_t  rem_ack,
  input  logic              flush,
  input  tcp_tx_pkg::byte_t in_dat,    // user byte stream
  input  logic              in_val,
  input  logic              in_snd,
  output logic              in_cts,
  output tcp_tx_pkg::seq_t  loc_seq,
  output tcp_tx_pkg::seq_t  pld_seq,   // segment info, held until sent
  output tcp_tx_pkg::len_t  pld_len,
  output tcp_tx_pkg::cks_t  pld_cks,
  output logic              send,
  input  logic              req,       // downstream byte request
  input  logic              sent,
  output logic              strm_val,
  output tcp_tx_pkg::byte_t strm_dat,
  output logic              strm_sof,
  output logic              strm_eof,
  output logic              force_dcn,
  output logic              flushed
);
  import tcp_tx_pkg::*;

  seq_t              ack_seq;
  logic              buf_full, busy;
  logic [BUF_AW-1:0] buf_addr;
  logic [PKT_AW:0]   pop_cnt;
  logic              pkz_wr, scn_wr;
  logic [PKT_AW-1:0] pkz_addr, scn_addr;
  pkt_info_t         pkz_dat, scn_dat, scn_q;

  ////////////////////
  // storage
  ////////////////////
  tcp_tx_data_buf #(.BUF_AW(BUF_AW)) u_data_buf (
    .clk(clk), .reset(reset), .init(init),
    .ack_seq(ack_seq), .wr_seq(loc_seq),
    .write(in_val && in_cts), .wr_dat(in_dat),
    .rd_addr(buf_addr), .rd_dat(strm_dat), .full(buf_full)
  );

  tcp_tx_pkt_ram #(.PKT_AW(PKT_AW)) u_pkt_ram (
    .clk(clk),
    .a_addr(pkz_addr), .a_wr(pkz_wr), .a_dat(pkz_dat), .a_q(),
    .b_addr(scn_addr), .b_wr(scn_wr), .b_dat(scn_dat), .b_q(scn_q)
  );

  ////////////////////
  // control
  ////////////////////
  tcp_tx_packetizer #(
    .MTU_PLD(MTU_PLD), .WAIT_TICKS(WAIT_TICKS), .RETX_TICKS(RETX_TICKS), .PKT_AW(PKT_AW)
  ) u_packetizer (
    .clk(clk), .reset(reset), .init(init), .init_seq(init_seq),
    .connected(connected), .flush(flush),
    .in_dat(in_dat), .in_val(in_val), .in_snd(in_snd), .in_cts(in_cts),
    .buf_full(buf_full), .pop_cnt(pop_cnt), .loc_seq(loc_seq),
    .rec_wr(pkz_wr), .rec_addr(pkz_addr), .rec_dat(pkz_dat), .busy(busy)
  );

  tcp_tx_retrans_ctl #(
    .RETX_TICKS(RETX_TICKS), .RETX_TRIES(RETX_TRIES), .BUF_AW(BUF_AW), .PKT_AW(PKT_AW)
  ) u_retrans_ctl (
    .clk(clk), .reset(reset), .init(init), .rem_ack(rem_ack), .flush(flush), .busy(busy),
    .rec_addr(scn_addr), .rec_wr(scn_wr), .rec_dat(scn_dat), .rec_q(scn_q),
    .pop_cnt(pop_cnt), .ack_seq(ack_seq), .buf_addr(buf_addr),
    .pld_seq(pld_seq), .pld_len(pld_len), .pld_cks(pld_cks),
    .send(send), .req(req), .sent(sent),
    .strm_val(strm_val), .strm_sof(strm_sof), .strm_eof(strm_eof),
    .force_dcn(force_dcn), .flushed(flushed)
  );

endmodule

// File: bench/tcp_tx_ctl_props.sv
`timescale 1ns/1ps

module tcp_tx_ctl_props (
  input logic             clk,
  input logic             reset,
  input logic             init,
  input logic             connected,
  input tcp_tx_pkg::seq_t loc_seq,
  input logic             send,
  input logic             sent,
  input logic             strm_sof,
  input logic             strm_eof
);
  logic open_frame; // sof seen and eof still pending

  always_ff @(posedge clk) begin
    if (reset) open_frame <= 1'b0;
    else if (strm_eof) open_frame <= 1'b0; // eof wins for one-byte frames
    else if (strm_sof) open_frame <= 1'b1;
  end

  a_send_pulse: assert property (@(posedge clk) disable iff (reset) send |=> !send)
    else $error("send held longer than one cycle");
  a_eof_before_sent: assert property (@(posedge clk) disable iff (reset) sent |-> !open_frame)
    else $error("sent while a frame is still open");
  a_cts_needs_conn: assert property (@(posedge clk) disable iff (reset)
    (!connected && !init) |=> $stable(loc_seq))
    else $error("byte taken without a connection");

endmodule

bind tcp_tx_ctl tcp_tx_ctl_props u_props (
  .clk(clk), .reset(reset), .init(init), .connected(connected), .loc_seq(loc_seq),
  .send(send), .sent(sent), .strm_sof(strm_sof), .strm_eof(strm_eof)
);

// File: bench/tcp_tx_ctl_tb.sv
`timescale 1ns/1ps

module tcp_tx_ctl_tb;
  import tcp_tx_pkg::*;

  localparam int MTU_PLD    = 16;
  localparam int WAIT_TICKS = 8;
  localparam int RETX_TICKS = 40;
  localparam int RETX_TRIES = 2;
  localparam int BUF_AW     = 6;
  localparam int PKT_AW     = 2;

  ////////////////////
  // time budget
  ////////////////////
  localparam int CLK_NS   = 4;
  localparam int SCAN_CYC = (2**PKT_AW) * (MTU_PLD + 13);   // worst pass over all records
  localparam int RETX_CYC = (RETX_TICKS + 2) * SCAN_CYC;   // bound on one retransmit period
  localparam int TEST_CYC = 16 + 12 * RETX_CYC;            // all waits of the run added up
  localparam int STALL_MAX = 64;                           // back-pressure detection window

  logic  clk, reset, init, connected, flush;
  seq_t  init_seq, rem_ack, loc_seq, pld_seq;
  byte_t in_dat, strm_dat;
  logic  in_val, in_snd, in_cts, send, req, sent;
  len_t  pld_len;
  cks_t  pld_cks;
  logic  strm_val, strm_sof, strm_eof, force_dcn, flushed;

  integer seed;
  byte_t  ref_bytes [seq_t];  // accepted bytes keyed by sequence number
  seq_t   next_seq;           // next sequence the user will write
  seq_t   tx_next;            // end of the stream sent for the first time
  seq_t   new_seq [$];        // first sends only
  len_t   new_len [$];
  seq_t   all_seq [$];        // every send including resends
  int     send_count;
  int     error_count;

  tcp_tx_ctl #(
    .MTU_PLD(MTU_PLD), .WAIT_TICKS(WAIT_TICKS), .RETX_TICKS(RETX_TICKS),
    .RETX_TRIES(RETX_TRIES), .BUF_AW(BUF_AW), .PKT_AW(PKT_AW)
  ) u_dut (
    .clk(clk), .reset(reset), .init(init), .init_seq(init_seq), .connected(connected),
    .rem_ack(rem_ack), .flush(flush), .in_dat(in_dat), .in_val(in_val), .in_snd(in_snd),
    .in_cts(in_cts), .loc_seq(loc_seq), .pld_seq(pld_seq), .pld_len(pld_len),
    .pld_cks(pld_cks), .send(send), .req(req), .sent(sent), .strm_val(strm_val),
    .strm_dat(strm_dat), .strm_sof(strm_sof), .strm_eof(strm_eof),
    .force_dcn(force_dcn), .flushed(flushed)
  );

  always #(CLK_NS / 2) clk = ~clk;

  ////////////////////
  // checking
  ////////////////////
  task automatic stop_run(input string what);
    error_count++;
    $display("ERROR: %s", what);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
      stop_run({"mismatch on ", name});
    end
  endtask

  function automatic byte_t ref_at(input seq_t a);
    if (ref_bytes.exists(a)) return ref_bytes[a];
    return 8'h00; // missing byte reads as zero
  endfunction

  // sum of big-endian 16-bit words with a zero low byte padding an odd tail
  function automatic cks_t expected_cks(input seq_t s, input int l);
    cks_t  sum;
    byte_t hi, lo;
    sum = '0;
    for (int i = 0; i < l; i += 2) begin
      hi  = ref_at(s + seq_t'(i));
      lo  = (i + 1 < l) ? ref_at(s + seq_t'(i + 1)) : 8'h00;
      sum = sum + cks_t'({hi, lo});
    end
    return sum;
  endfunction

  ////////////////////
  // downstream frame builder model
  ////////////////////
  task automatic serve_segment();
    seq_t s;
    seq_t age;
    len_t l;
    int   n;
    int   cyc;
    s = pld_seq; // held from the send pulse until sent
    l = pld_len;
    n = 0;
    cyc = 0;
    if (l == 0 || l > MTU_PLD) stop_run("segment length out of range");
    check("pld_cks", pld_cks, expected_cks(s, l));
    #1 req = 1'b1;
    while (n < l) begin
      @(posedge clk);
      cyc++;
      if (strm_val) begin
        if (!ref_bytes.exists(s + seq_t'(n))) stop_run("streamed byte was never written");
        check("strm_dat", strm_dat, ref_bytes[s + seq_t'(n)]);
        check("strm_sof", strm_sof, n == 0);
        check("strm_eof", strm_eof, n == l - 1);
        n++;
      end
      if (cyc > l + 16) stop_run("byte stream stalled with req held high");
    end
    #1 req = 1'b0;
    sent = 1'b1;
    @(posedge clk);
    #1 sent = 1'b0;
    age = tx_next - s;
    if (age == '0) begin // first send of this segment
      new_seq.push_back(s);
      new_len.push_back(l);
      tx_next = tx_next + seq_t'(l);
    end else if (age[31] || age < seq_t'(l)) begin
      stop_run("segment start is ahead of the sent stream");
    end
    all_seq.push_back(s);
    send_count++;
  endtask

  initial begin
    forever begin
      @(posedge clk);
      if (!reset && send) serve_segment();
    end
  end

  ////////////////////
  // helpers
  ////////////////////
  task automatic idle_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic start_connection(input seq_t s);
    init_seq  = s;
    rem_ack   = s;
    connected = 1'b1;
    init      = 1'b1;
    next_seq  = s;
    tx_next   = s;
    @(posedge clk);
    #1 init = 1'b0;
  endtask

  // returns how many bytes went in before in_cts stayed low for stall_max cycles
  task automatic write_bytes(input int n, input int stall_max, output int done_cnt);
    int stall;
    done_cnt = n;
    for (int i = 0; i < n; i++) begin
      in_dat = byte_t'($random(seed));
      in_val = 1'b1;
      stall  = 0;
      @(posedge clk);
      while (!in_cts) begin
        stall++;
        if (stall >= stall_max) begin
          #1 in_val = 1'b0;
          done_cnt = i;
          return;
        end
        @(posedge clk);
      end
      ref_bytes[next_seq] = in_dat;
      next_seq = next_seq + 1'b1;
      #1;
    end
    in_val = 1'b0;
    check("loc_seq", loc_seq, next_seq);
  endtask

  task automatic write_all(input int n);
    int got;
    write_bytes(n, RETX_CYC, got);
    if (got != n) stop_run("in_cts stuck low while writing");
  endtask

  task automatic wait_all_sent();
    int cyc;
    cyc = 0;
    while (tx_next != next_seq) begin
      @(posedge clk);
      cyc++;
      if (cyc > 2 * RETX_CYC) stop_run("written bytes were not sent in time");
    end
    #1;
  endtask

  task automatic wait_send_count(input int n);
    int cyc;
    cyc = 0;
    while (send_count < n) begin
      @(posedge clk);
      cyc++;
      if (cyc > 2 * RETX_CYC) stop_run("no retransmission within the retransmit bound");
    end
    #1;
  endtask

  task automatic ack_all();
    int cyc;
    cyc = 0;
    rem_ack = next_seq;
    while (u_dut.ack_seq != next_seq) begin // free pointer reaches the ack
      @(posedge clk);
      cyc++;
      if (cyc > 2 * SCAN_CYC) stop_run("acknowledged segments were not freed");
    end
    #1;
  endtask

  ////////////////////
  // directed tests
  ////////////////////
  task automatic test_reset_quiet();
    in_dat = 8'h5a; // offered byte must be refused while disconnected
    in_val = 1'b1;
    for (int i = 0; i < 20; i++) begin
      @(posedge clk);
      check("in_cts", in_cts, 0);
      check("send", send, 0);
      check("strm_val", strm_val, 0);
      check("force_dcn", force_dcn, 0);
      check("flushed", flushed, 0);
    end
    #1;
    in_val = 1'b0;
  endtask

  task automatic test_single_segment();
    int mark;
    start_connection(32'hffff_ffe0); // stream wraps the sequence space later
    mark = new_seq.size();
    write_all(5);
    wait_all_sent();
    check("segments", new_seq.size() - mark, 1);
    check("pld_seq", new_seq[mark], 32'hffff_ffe0);
    check("pld_len", new_len[mark], 5);
    ack_all();
  endtask

  task automatic test_segment_sizes();
    int   mark;
    seq_t s;
    mark = new_seq.size();
    s = next_seq;
    write_all(40);
    wait_all_sent();
    check("segments", new_seq.size() - mark, 3);
    check("pld_len", new_len[mark], MTU_PLD);
    check("pld_len", new_len[mark + 1], MTU_PLD);
    check("pld_len", new_len[mark + 2], 40 - 2 * MTU_PLD);
    check("pld_seq", new_seq[mark], s);
    check("pld_seq", new_seq[mark + 1], s + MTU_PLD);
    check("pld_seq", new_seq[mark + 2], s + 2 * MTU_PLD);
    ack_all();
    // forced close with more bytes right behind it
    mark = new_seq.size();
    s = next_seq;
    write_all(3);
    in_snd = 1'b1;
    @(posedge clk);
    #1 in_snd = 1'b0;
    write_all(5);
    wait_all_sent();
    check("segments", new_seq.size() - mark, 2);
    check("pld_len", new_len[mark], 3);
    check("pld_len", new_len[mark + 1], 5);
    check("pld_seq", new_seq[mark + 1], s + 3);
    ack_all();
  endtask

  task automatic test_retransmit();
    int   c0;
    seq_t s;
    write_all(4);
    wait_all_sent();
    ack_all();
    c0 = send_count;
    idle_cycles(RETX_CYC); // covered segment must stay quiet
    check("send_count", send_count, c0);
    s = next_seq;
    write_all(6);
    wait_all_sent();
    c0 = send_count;
    wait_send_count(c0 + 1);
    check("resend pld_seq", all_seq[all_seq.size() - 1], s);
    check("force_dcn", force_dcn, 0);
    wait_send_count(c0 + RETX_TRIES);
    check("resend pld_seq", all_seq[all_seq.size() - 1], s);
    check("force_dcn", force_dcn, 1); // out of retries
    ack_all();
  endtask

  task automatic test_back_pressure();
    int got;
    write_bytes(4 * MTU_PLD, STALL_MAX, got);
    if (got >= 4 * MTU_PLD) stop_run("in_cts never dropped with storage full");
    if (got < MTU_PLD) stop_run("in_cts dropped before a full segment fit");
    check("loc_seq", loc_seq, next_seq);
    wait_all_sent();
    ack_all();
    write_all(12); // writing resumes once freed
    wait_all_sent();
    ack_all();
  endtask

  task automatic test_flush();
    int c0;
    int cyc;
    write_all(5);
    wait_all_sent();
    flush = 1'b1;
    cyc = 0;
    @(posedge clk);
    while (!flushed) begin
      cyc++;
      if (cyc > 2 * SCAN_CYC) stop_run("no flushed pulse after flush request");
      @(posedge clk);
    end
    #1 flush = 1'b0;
    c0 = send_count;
    idle_cycles(RETX_CYC);
    check("send_count", send_count, c0);
    start_connection(32'h1234_5000);
    check("force_dcn", force_dcn, 0);
    write_all(3);
    wait_all_sent();
    check("pld_seq", new_seq[new_seq.size() - 1], 32'h1234_5000);
    check("pld_len", new_len[new_len.size() - 1], 3);
    ack_all();
  endtask

  ////////////////////
  // main
  ////////////////////
  initial begin
    seed = 32'h17fd_e9e2;
    clk = 1'b0;
    reset = 1'b1;
    init = 1'b0;
    init_seq = '0;
    connected = 1'b0;
    rem_ack = '0;
    flush = 1'b0;
    in_dat = '0;
    in_val = 1'b0;
    in_snd = 1'b0;
    req = 1'b0;
    sent = 1'b0;
    next_seq = '0;
    tx_next = '0;
    send_count = 0;
    error_count = 0;
    repeat (16) @(posedge clk);
    #1 reset = 1'b0;
    test_reset_quiet();
    test_single_segment();
    test_segment_sizes();
    test_retransmit();
    test_back_pressure();
    test_flush();
    check("tx_next", tx_next, next_seq); // nothing written went unsent
    if (error_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  initial begin
    #(longint'(TEST_CYC) * CLK_NS);
    stop_run("watchdog expired before the tests finished");
  end

endmodule

// File: build.f
logic/tcp_tx_pkg.sv
logic/tcp_tx_data_buf.sv
logic/tcp_tx_pkt_ram.sv
logic/tcp_tx_packetizer.sv
logic/tcp_tx_retrans_ctl.sv
logic/tcp_tx_ctl.sv
bench/tcp_tx_ctl_props.sv
bench/tcp_tx_ctl_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tcp_tx_ctl_tb
FILELIST  = build.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	! grep -q "TEST FAIL" $(LOG)
	grep -q "TEST PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
